/* thumb_decoder_settings.svh */
`ifndef THUMB_DECODER_SETTINGS_SVH
`define THUMB_DECODER_SETTINGS_SVH

// Widths
`define THUMB_W         16      // Compressed halfword
`define ARM_W           32      // Full ARM word
`define EXP_W           35      // ARM word plus 3 extension bits
`define BL_OFF_W        11      // Upper half of BL offset

// Condition codes
`define COND_AL         4'b1110
`define COND_NV         4'b1111 // Never, used as BL prefix marker

//////////////////////////////////////////////////
// ARM data-processing opcodes, bits 24:21
//////////////////////////////////////////////////
`define OP_AND          4'b0000
`define OP_EOR          4'b0001
`define OP_SUB          4'b0010
`define OP_RSB          4'b0011
`define OP_ADD          4'b0100
`define OP_ADC          4'b0101
`define OP_SBC          4'b0110
`define OP_TST          4'b1000
`define OP_CMP          4'b1010
`define OP_CMN          4'b1011
`define OP_ORR          4'b1100
`define OP_MOV          4'b1101
`define OP_BIC          4'b1110
`define OP_MVN          4'b1111

// Barrel shifter types
`define SH_LSL          2'b00
`define SH_LSR          2'b01
`define SH_ASR          2'b10
`define SH_ROR          2'b11

//////////////////////////////////////////////////
// Instruction classes from the classifier
//////////////////////////////////////////////////
`define CLS_SHIFT               4'd0
`define CLS_MCAS_IMM            4'd1
`define CLS_ADD_SUB_LO          4'd2
`define CLS_ALU_LO              4'd3
`define CLS_ALU_HI              4'd4
`define CLS_BX                  4'd5
`define CLS_SWI                 4'd6
`define CLS_BRANCH_COND         4'd7
`define CLS_BRANCH_NOCOND       4'd8
`define CLS_BL                  4'd9
`define CLS_UND                 4'd15       // Loads, stores and v5 ops land here

`endif

/* thumb_pkg.sv */
`include "thumb_decoder_settings.svh"

package thumb_pkg;

        //////////////////////////////////////////////////
        // Instruction words
        //////////////////////////////////////////////////

        // One compressed instruction
        typedef logic [`THUMB_W-1:0]    halfword_t;

        // ARM instruction, or raw fetch word in ARM mode
        typedef logic [`ARM_W-1:0]      arm_word_t;

        // Bit 34 flags a halfword-scaled branch offset
        // Bits 33:32 stay zero in this decoder
        typedef logic [`EXP_W-1:0]      expanded_t;

        //////////////////////////////////////////////////
        // Fields
        //////////////////////////////////////////////////

        // Register number, R0 to R15
        typedef logic [3:0]             reg_idx_t;

        // Classifier output, see CLS_* codes
        typedef logic [3:0]             insn_class_t;

        // Offset bits carried from BL prefix to suffix
        typedef logic [`BL_OFF_W-1:0]   bl_offset_t;

endpackage

/* thumb_class_decode.sv */
`include "thumb_decoder_settings.svh"

module thumb_class_decode import thumb_pkg::*;
(
        input  halfword_t       i_halfword,     // Low half of fetch word
        output insn_class_t     o_class         // Class code for the expanders
);

//////////////////////////////////////////////////
// Opcode field matches
//////////////////////////////////////////////////

logic is_swi;
logic is_add_sub_lo;
logic is_bx;
logic is_shift;
logic is_mcas_imm;
logic is_alu_lo;
logic is_alu_hi;
logic is_branch_cond;
logic is_branch_nocond;
logic is_bl;

assign is_swi           = (i_halfword[15:8]  == 8'b1101_1111);   // Cond field 1111 in B<cond>
assign is_add_sub_lo    = (i_halfword[15:11] == 5'b00011);      // Shift type 11 slot
assign is_bx            = (i_halfword[15:7]  == 9'b0100_0111_0);  // H1 must be clear
assign is_shift         = (i_halfword[15:13] == 3'b000);
assign is_mcas_imm      = (i_halfword[15:13] == 3'b001);
assign is_alu_lo        = (i_halfword[15:10] == 6'b010000);
assign is_alu_hi        = (i_halfword[15:10] == 6'b010001) &&
                          (i_halfword[9:8]   != 2'b11);         // Op 11 is BX/BLX
assign is_branch_cond   = (i_halfword[15:12] == 4'b1101);
assign is_branch_nocond = (i_halfword[15:11] == 5'b11100);
assign is_bl            = (i_halfword[15:12] == 4'b1111);       // Both halves of the pair

//////////////////////////////////////////////////
// Priority select
//////////////////////////////////////////////////

// Overlapping encodings resolved by order
always_comb
begin
        if (is_swi)
                o_class = `CLS_SWI;             // Ahead of conditional branch
        else if (is_add_sub_lo)
                o_class = `CLS_ADD_SUB_LO;      // Ahead of shift
        else if (is_bx)
                o_class = `CLS_BX;              // Ahead of high register ops
        else if (is_shift)
                o_class = `CLS_SHIFT;
        else if (is_mcas_imm)
                o_class = `CLS_MCAS_IMM;
        else if (is_alu_lo)
                o_class = `CLS_ALU_LO;
        else if (is_alu_hi)
                o_class = `CLS_ALU_HI;
        else if (is_branch_cond)
                o_class = `CLS_BRANCH_COND;
        else if (is_branch_nocond)
                o_class = `CLS_BRANCH_NOCOND;
        else if (is_bl)
                o_class = `CLS_BL;
        else
        begin
                // Memory ops, SP/PC arithmetic, BKPT, BLX
                o_class = `CLS_UND;
        end
end

endmodule

/* thumb_dp_expand.sv */
`include "thumb_decoder_settings.svh"

module thumb_dp_expand import thumb_pkg::*;
(
        input  halfword_t       i_halfword,
        input  insn_class_t     i_class,
        output expanded_t       o_expanded      // Zero unless class is data processing
);

//////////////////////////////////////////////////
// Field extraction
//////////////////////////////////////////////////

reg_idx_t       rd_lo;          // Bits 2:0
reg_idx_t       rs_lo;          // Bits 5:3
reg_idx_t       rn_lo;          // Bits 8:6, register or imm3
reg_idx_t       rd_imm;         // Bits 10:8 for 8-bit immediate forms
reg_idx_t       rd_hi;          // H1 and bits 2:0
reg_idx_t       rs_hi;          // H2 and bits 5:3
logic [1:0]     mcas_op;
logic [1:0]     hi_op;
logic [3:0]     alu_op;
arm_word_t      arm_word;

assign rd_lo    = {1'b0, i_halfword[2:0]};
assign rs_lo    = {1'b0, i_halfword[5:3]};
assign rn_lo    = {1'b0, i_halfword[8:6]};
assign rd_imm   = {1'b0, i_halfword[10:8]};
assign rd_hi    = {i_halfword[7], i_halfword[2:0]};
assign rs_hi    = {i_halfword[6], i_halfword[5:3]};
assign mcas_op  = i_halfword[12:11];
assign hi_op    = i_halfword[9:8];
assign alu_op   = i_halfword[9:6];

// Data-processing word, condition always
function automatic arm_word_t build_dp(
        input logic             imm,
        input logic [3:0]       opcode,
        input logic             set_flags,
        input reg_idx_t         rn,
        input reg_idx_t         rd,
        input logic [11:0]      op2
);
        return {`COND_AL, 2'b00, imm, opcode, set_flags, rn, rd, op2};
endfunction

// Operand 2 as Rm shifted by Rs
function automatic logic [11:0] reg_shift(
        input reg_idx_t         rs,
        input logic [1:0]       sh_type,
        input reg_idx_t         rm
);
        return {rs, 1'b0, sh_type, 1'b1, rm};
endfunction

//////////////////////////////////////////////////
// Class expansion
//////////////////////////////////////////////////

always_comb
begin
        arm_word = '0;  // Foreign classes give zero

        case (i_class)
        `CLS_SHIFT:
                // MOVS Rd, Rs, <type> #imm5
                arm_word = build_dp(1'b0, `OP_MOV, 1'b1, 4'd0, rd_lo,
                                    {i_halfword[10:6], i_halfword[12:11], 1'b0, rs_lo});

        `CLS_MCAS_IMM:
        begin
                case (mcas_op)
                2'd0:    arm_word = build_dp(1'b1, `OP_MOV, 1'b1, rd_imm, rd_imm,
                                             {4'd0, i_halfword[7:0]});
                2'd1:    arm_word = build_dp(1'b1, `OP_CMP, 1'b1, rd_imm, rd_imm,
                                             {4'd0, i_halfword[7:0]});
                2'd2:    arm_word = build_dp(1'b1, `OP_ADD, 1'b1, rd_imm, rd_imm,
                                             {4'd0, i_halfword[7:0]});
                default: arm_word = build_dp(1'b1, `OP_SUB, 1'b1, rd_imm, rd_imm,
                                             {4'd0, i_halfword[7:0]});
                endcase
        end

        `CLS_ADD_SUB_LO:
                // Bit 10 picks imm3, bit 9 picks SUB
                // Same operand2 bits either way
                arm_word = build_dp(i_halfword[10], i_halfword[9] ? `OP_SUB : `OP_ADD,
                                    1'b1, rs_lo, rd_lo, {8'd0, rn_lo});

        `CLS_ALU_LO:
        begin
                case (alu_op)
                4'd0:    arm_word = build_dp(1'b0, `OP_AND, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd1:    arm_word = build_dp(1'b0, `OP_EOR, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd2:    arm_word = build_dp(1'b0, `OP_MOV, 1'b1, rd_lo, rd_lo,
                                             reg_shift(rs_lo, `SH_LSL, rd_lo));
                4'd3:    arm_word = build_dp(1'b0, `OP_MOV, 1'b1, rd_lo, rd_lo,
                                             reg_shift(rs_lo, `SH_LSR, rd_lo));
                4'd4:    arm_word = build_dp(1'b0, `OP_MOV, 1'b1, rd_lo, rd_lo,
                                             reg_shift(rs_lo, `SH_ASR, rd_lo));
                4'd5:    arm_word = build_dp(1'b0, `OP_ADC, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd6:    arm_word = build_dp(1'b0, `OP_SBC, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd7:    arm_word = build_dp(1'b0, `OP_MOV, 1'b1, rd_lo, rd_lo,
                                             reg_shift(rs_lo, `SH_ROR, rd_lo));
                4'd8:    arm_word = build_dp(1'b0, `OP_TST, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd9:    arm_word = build_dp(1'b1, `OP_RSB, 1'b1, rs_lo, rd_lo, 12'd0); // NEG
                4'd10:   arm_word = build_dp(1'b0, `OP_CMP, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd11:   arm_word = build_dp(1'b0, `OP_CMN, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd12:   arm_word = build_dp(1'b0, `OP_ORR, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                4'd13:
                        // MULS Rd, Rs, Rd in multiply format
                        arm_word = {`COND_AL, 7'b0000000, 1'b1, rd_lo, 4'd0, rd_lo,
                                    4'b1001, rs_lo};
                4'd14:   arm_word = build_dp(1'b0, `OP_BIC, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                default: arm_word = build_dp(1'b0, `OP_MVN, 1'b1, rd_lo, rd_lo, {8'd0, rs_lo});
                endcase
        end

        `CLS_ALU_HI:
        begin
                // Only CMP touches flags
                case (hi_op)
                2'd0:    arm_word = build_dp(1'b0, `OP_ADD, 1'b0, rd_hi, rd_hi, {8'd0, rs_hi});
                2'd1:    arm_word = build_dp(1'b0, `OP_CMP, 1'b1, rd_hi, rd_hi, {8'd0, rs_hi});
                2'd2:    arm_word = build_dp(1'b0, `OP_MOV, 1'b0, rd_hi, rd_hi, {8'd0, rs_hi});
                default: arm_word = '0;         // Op 11 never classified here
                endcase
        end

        default:
                arm_word = '0;
        endcase
end

assign o_expanded = {3'b000, arm_word};        // Extension bits always clear

endmodule

/* thumb_branch_expand.sv */
`include "thumb_decoder_settings.svh"

module thumb_branch_expand import thumb_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  halfword_t       i_halfword,
        input  insn_class_t     i_class,
        input  logic            i_accept,       // Valid word in compressed mode
        output expanded_t       o_expanded,     // Zero unless class is control flow
        output logic            o_int_mask      // Hold off IRQ/FIQ inside a BL pair
);

//////////////////////////////////////////////////
// BL prefix offset register
//////////////////////////////////////////////////

bl_offset_t     bl_off_q;       // Upper 11 bits from last prefix
logic           bl_prefix;      // BL with H clear
logic [23:0]    cond_off;
logic [23:0]    nocond_off;
logic [23:0]    bl_off;

assign bl_prefix = (i_class == `CLS_BL) && !i_halfword[11];

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
                bl_off_q <= '0;
        else if (i_accept && bl_prefix)
                bl_off_q <= i_halfword[10:0];  // Only accepted prefixes count
end

//////////////////////////////////////////////////
// Offsets
//////////////////////////////////////////////////

// Halfword units, scaled downstream via bit 34
assign cond_off   = {{16{i_halfword[7]}}, i_halfword[7:0]};
assign nocond_off = {{13{i_halfword[10]}}, i_halfword[10:0]};

// 22-bit combined offset, minus one to stay relative to the prefix
assign bl_off     = {{2{bl_off_q[10]}}, bl_off_q, i_halfword[10:0]} - 24'd1;

//////////////////////////////////////////////////
// Class expansion
//////////////////////////////////////////////////

always_comb
begin
        o_expanded = '0;

        case (i_class)
        `CLS_BRANCH_COND:
                o_expanded = {1'b1, 2'b00, i_halfword[11:8], 3'b101, 1'b0, cond_off};

        `CLS_BRANCH_NOCOND:
                o_expanded = {1'b1, 2'b00, `COND_AL, 3'b101, 1'b0, nocond_off};

        `CLS_BL:
        begin
                if (bl_prefix)
                begin
                        // Dummy NV word, low 12 bits ride along
                        o_expanded = {3'b000, `COND_NV, 16'd0, i_halfword[11:0]};
                end
                else
                begin
                        o_expanded = {1'b1, 2'b00, `COND_AL, 3'b101, 1'b1, bl_off}; // Link set
                end
        end

        `CLS_BX:
                // BX Rm, H2 gives Rm[3]
                o_expanded = {3'b000, `COND_AL, 24'h12_FFF1, i_halfword[6:3]};

        `CLS_SWI:
                o_expanded = {3'b000, `COND_AL, 4'b1111, 16'd0, i_halfword[7:0]};

        default:
                o_expanded = '0;
        endcase
end

// Both halves, so no interrupt splits the pair
assign o_int_mask = (i_class == `CLS_BL);

endmodule

/* thumb_decoder.sv */
`include "thumb_decoder_settings.svh"

module thumb_decoder import thumb_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,

        // Fetch side
        input  arm_word_t       i_instruction,
        input  logic            i_instruction_valid,
        input  logic            i_cpsr_t,               // T bit, compressed mode
        input  logic            i_irq,
        input  logic            i_fiq,

        // To the ARM decoder, one cycle later
        output expanded_t       o_instruction,
        output logic            o_instruction_valid,
        output logic            o_und,
        output logic            o_irq,
        output logic            o_fiq
);

//////////////////////////////////////////////////
// Expansion datapath
//////////////////////////////////////////////////

halfword_t      halfword;
insn_class_t    insn_class;
expanded_t      dp_exp;
expanded_t      br_exp;
logic           int_mask;
logic           accept;

assign halfword = i_instruction[`THUMB_W-1:0];         // Upper half ignored in T mode
assign accept   = i_instruction_valid && i_cpsr_t;

thumb_class_decode u_class_decode (
        .i_halfword     (halfword),
        .o_class        (insn_class)
);

thumb_dp_expand u_dp_expand (
        .i_halfword     (halfword),
        .i_class        (insn_class),
        .o_expanded     (dp_exp)
);

thumb_branch_expand u_branch_expand (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_halfword     (halfword),
        .i_class        (insn_class),
        .i_accept       (accept),
        .o_expanded     (br_exp),
        .o_int_mask     (int_mask)
);

//////////////////////////////////////////////////
// Output register stage
//////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (!i_rst_n)
        begin
                o_instruction           <= '0;
                o_instruction_valid     <= 1'b0;
                o_und                   <= 1'b0;
                o_irq                   <= 1'b0;
                o_fiq                   <= 1'b0;
        end
        else
        begin
                o_instruction_valid     <= i_instruction_valid;
                if (accept)
                begin
                        o_instruction   <= dp_exp | br_exp;     // Disjoint, the other is zero
                        o_und           <= (insn_class == `CLS_UND);
                        o_irq           <= i_irq && !int_mask;
                        o_fiq           <= i_fiq && !int_mask;
                end
                else
                begin
                        // ARM mode or bubble, pass through
                        o_instruction   <= {3'b000, i_instruction};
                        o_und           <= 1'b0;
                        o_irq           <= i_irq;
                        o_fiq           <= i_fiq;
                end
        end
end

endmodule

/* thumb_decoder_assertions.sv */
`include "thumb_decoder_settings.svh"

module thumb_decoder_assertions import thumb_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_rst_n,
        input  logic            i_instruction_valid,
        input  logic            i_cpsr_t,
        input  expanded_t       i_out_instruction,
        input  logic            i_out_valid,
        input  logic            i_out_und,
        input  logic            i_out_irq,
        input  logic            i_out_fiq
);

// Exactly one cycle from fetch valid to output valid
valid_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> (i_out_valid == $past(i_instruction_valid)))
else $error("output valid does not follow input valid by one cycle");

// Undefined flag only on a real word
und_has_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_und |-> i_out_valid)
else $error("undefined flag raised without output valid");

// NV marks a BL prefix in compressed mode, no interrupt may split the pair
bl_prefix_masked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_out_valid && $past(i_cpsr_t) && (i_out_instruction[31:28] == `COND_NV))
        |-> (!i_out_irq && !i_out_fiq))
else $error("interrupt passed on a BL prefix word");

endmodule

bind thumb_decoder thumb_decoder_assertions u_assertions (
        .i_clk                  (i_clk),
        .i_rst_n                (i_rst_n),
        .i_instruction_valid    (i_instruction_valid),
        .i_cpsr_t               (i_cpsr_t),
        .i_out_instruction      (o_instruction),
        .i_out_valid            (o_instruction_valid),
        .i_out_und              (o_und),
        .i_out_irq              (o_irq),
        .i_out_fiq              (o_fiq)
);

/* tb_thumb_decoder.sv */
`include "thumb_decoder_settings.svh"

module tb_thumb_decoder import thumb_pkg::*;
();

localparam int TIMEOUT = 16;    // Edges allowed per output

logic           clk;
logic           rst_n;
arm_word_t      instruction;
logic           instruction_valid;
logic           cpsr_t;
logic           irq;
logic           fiq;
expanded_t      out_instruction;
logic           out_valid;
logic           und;
logic           out_irq;
logic           out_fiq;
logic [15:0]    lfsr;           // Stimulus state
int             last_latency;   // Edges from issue to output valid

thumb_decoder i_thumb_decoder (
        .i_clk                  (clk),
        .i_rst_n                (rst_n),
        .i_instruction          (instruction),
        .i_instruction_valid    (instruction_valid),
        .i_cpsr_t               (cpsr_t),
        .i_irq                  (irq),
        .i_fiq                  (fiq),
        .o_instruction          (out_instruction),
        .o_instruction_valid    (out_valid),
        .o_und                  (und),
        .o_irq                  (out_irq),
        .o_fiq                  (out_fiq)
);

initial
begin
        clk = 1'b0;
        forever #10 clk = ~clk;
end

//////////////////////////////////////////////////
// Stimulus and expected words
//////////////////////////////////////////////////

// Taps 16 14 13 11 stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
        logic [31:0]    r;
        logic           fb;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
                fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
                lfsr = {lfsr[14:0], fb};
                r    = {r[30:0], fb};
        end
        return r;
endfunction

// ARM data-processing format with AL and no extension bits
function automatic expanded_t dp_word(input logic imm, input logic [3:0] op, input logic s,
                                     input reg_idx_t rn, input reg_idx_t rd,
                                     input logic [11:0] op2);
        return {3'b000, `COND_AL, 2'b00, imm, op, s, rn, rd, op2};
endfunction

// B/BL with halfword-scaled offset flag
function automatic expanded_t branch_word(input logic [3:0] cond, input logic link,
                                          input logic [23:0] off);
        return {1'b1, 2'b00, cond, 3'b101, link, off};
endfunction

function automatic expanded_t alu_lo_word(input logic [3:0] op, input reg_idx_t rs,
                                          input reg_idx_t rd);
        expanded_t w;
        case (op)
        4'd0:    w = dp_word(1'b0, `OP_AND, 1'b1, rd, rd, {8'd0, rs});
        4'd1:    w = dp_word(1'b0, `OP_EOR, 1'b1, rd, rd, {8'd0, rs});
        4'd2:    w = dp_word(1'b0, `OP_MOV, 1'b1, rd, rd, {rs, 1'b0, `SH_LSL, 1'b1, rd});
        4'd3:    w = dp_word(1'b0, `OP_MOV, 1'b1, rd, rd, {rs, 1'b0, `SH_LSR, 1'b1, rd});
        4'd4:    w = dp_word(1'b0, `OP_MOV, 1'b1, rd, rd, {rs, 1'b0, `SH_ASR, 1'b1, rd});
        4'd5:    w = dp_word(1'b0, `OP_ADC, 1'b1, rd, rd, {8'd0, rs});
        4'd6:    w = dp_word(1'b0, `OP_SBC, 1'b1, rd, rd, {8'd0, rs});
        4'd7:    w = dp_word(1'b0, `OP_MOV, 1'b1, rd, rd, {rs, 1'b0, `SH_ROR, 1'b1, rd});
        4'd8:    w = dp_word(1'b0, `OP_TST, 1'b1, rd, rd, {8'd0, rs});
        4'd9:    w = dp_word(1'b1, `OP_RSB, 1'b1, rs, rd, 12'd0);       // NEG
        4'd10:   w = dp_word(1'b0, `OP_CMP, 1'b1, rd, rd, {8'd0, rs});
        4'd11:   w = dp_word(1'b0, `OP_CMN, 1'b1, rd, rd, {8'd0, rs});
        4'd12:   w = dp_word(1'b0, `OP_ORR, 1'b1, rd, rd, {8'd0, rs});
        4'd13:   w = {3'b000, `COND_AL, 7'd0, 1'b1, rd, 4'd0, rd, 4'b1001, rs}; // MULS
        4'd14:   w = dp_word(1'b0, `OP_BIC, 1'b1, rd, rd, {8'd0, rs});
        default: w = dp_word(1'b0, `OP_MVN, 1'b1, rd, rd, {8'd0, rs});
        endcase
        return w;
endfunction

//////////////////////////////////////////////////
// Drive and check
//////////////////////////////////////////////////

task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation aborted");
endtask

// One word in and wait for the registered result
task automatic issue(input arm_word_t word, input logic t_mode, input logic ir, input logic fr);
        int     cycles;
        logic   seen;
        @(posedge clk);
        #1;
        instruction       = word;
        cpsr_t            = t_mode;
        irq               = ir;
        fiq               = fr;
        instruction_valid = 1'b1;
        cycles            = 0;
        seen              = 1'b0;
        while (!seen && cycles < TIMEOUT)
        begin
                @(posedge clk);
                #1;
                instruction_valid = 1'b0;       // Single strobe
                cycles++;
                seen = out_valid;
        end
        if (!seen)
        begin
                $display("timeout waiting for output valid after %0d cycles", TIMEOUT);
                abort_run();
        end
        else
                last_latency = cycles;
endtask

// Upper half is noise the DUT must ignore
task automatic issue_thumb(input halfword_t hw, input logic ir, input logic fr);
        halfword_t upper;
        upper = 16'(rand_bits(16));
        issue({upper, hw}, 1'b1, ir, fr);
endtask

task automatic check_out(input expanded_t exp_word, input logic exp_und, input logic exp_irq,
                         input logic exp_fiq, input string what);
        assert (out_valid && out_instruction == exp_word)
        else
        begin
                $display("error: time %0t %s gave %h, expected %h", $time, what,
                         out_instruction, exp_word);
                abort_run();
        end
        assert ({und, out_irq, out_fiq} == {exp_und, exp_irq, exp_fiq})
        else
        begin
                $display("error: time %0t %s und/irq/fiq %b, expected %b", $time, what,
                         {und, out_irq, out_fiq}, {exp_und, exp_irq, exp_fiq});
                abort_run();
        end
endtask

// Random interrupts pass unmasked outside BL
task automatic run_thumb(input halfword_t hw, input expanded_t exp_word, input string what);
        logic ir;
        logic fr;
        ir = 1'(rand_bits(1));
        fr = 1'(rand_bits(1));
        issue_thumb(hw, ir, fr);
        check_out(exp_word, 1'b0, ir, fr, what);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic reset_and_latency();
        for (int c = 0; c < 3; c++)
        begin
                @(posedge clk);
                #1;
                assert (!out_valid && !und && !out_irq && !out_fiq && out_instruction == '0)
                else
                begin
                        $display("error: time %0t outputs active during reset", $time);
                        abort_run();
                end
        end
        rst_n = 1'b1;
        issue(32'hE1A0_0000, 1'b0, 1'b0, 1'b0);        // ARM NOP
        assert (last_latency == 1)
        else
        begin
                $display("error: time %0t latency %0d, expected 1", $time, last_latency);
                abort_run();
        end
endtask

task automatic arm_pass_through();
        arm_word_t      word;
        logic           ir;
        logic           fr;
        for (int k = 0; k < 8; k++)
        begin
                word = rand_bits(32);
                ir   = 1'(rand_bits(1));
                fr   = 1'(rand_bits(1));
                issue(word, 1'b0, ir, fr);
                check_out({3'b000, word}, 1'b0, ir, fr, "ARM pass-through");
        end
endtask

task automatic data_processing();
        logic [2:0]     d;
        logic [2:0]     s;
        logic [2:0]     n;
        logic           h1;
        logic           h2;
        logic [7:0]     imm8;
        logic [4:0]     imm5;
        logic [3:0]     op;
        for (int k = 0; k < 4; k++)
        begin
                d    = 3'(rand_bits(3));
                imm8 = 8'(rand_bits(8));
                op   = (k == 0) ? `OP_MOV : (k == 1) ? `OP_CMP : (k == 2) ? `OP_ADD : `OP_SUB;
                run_thumb({3'b001, 2'(k), d, imm8},
                          dp_word(1'b1, op, 1'b1, {1'b0, d}, {1'b0, d}, {4'd0, imm8}), "MCAS imm");
                // Bit 10 selects immediate and bit 9 subtract
                s = 3'(rand_bits(3));
                n = 3'(rand_bits(3));
                run_thumb({5'b00011, 2'(k), n, s, d},
                          dp_word(k[1], k[0] ? `OP_SUB : `OP_ADD, 1'b1, {1'b0, s}, {1'b0, d},
                                  {9'd0, n}), "add/sub low");
        end
        for (int k = 0; k < 16; k++)
        begin
                d = 3'(rand_bits(3));
                s = 3'(rand_bits(3));
                run_thumb({6'b010000, 4'(k), s, d},
                          alu_lo_word(4'(k), {1'b0, s}, {1'b0, d}), "ALU low");
        end
        for (int k = 0; k < 3; k++)
        begin
                d    = 3'(rand_bits(3));
                s    = 3'(rand_bits(3));
                h1   = 1'(rand_bits(1));
                h2   = 1'(rand_bits(1));
                imm5 = 5'(rand_bits(5));
                op   = (k == 0) ? `OP_ADD : (k == 1) ? `OP_CMP : `OP_MOV;
                run_thumb({6'b010001, 2'(k), h1, h2, s, d},
                          dp_word(1'b0, op, k == 1, {h1, d}, {h1, d}, {8'd0, h2, s}), "ALU high");
                run_thumb({3'b000, 2'(k), imm5, s, d},
                          dp_word(1'b0, `OP_MOV, 1'b1, 4'd0, {1'b0, d}, {imm5, 2'(k), 2'b00, s}),
                          "shift imm");
        end
endtask

task automatic control_flow();
        logic [7:0]     off8 [3];
        logic [10:0]    off11 [2];
        logic [3:0]     cond;
        logic [7:0]     imm8;
        logic [3:0]     rm;
        off8[0]  = 8'h05;               // Forward
        off8[1]  = 8'hF0;               // Backward
        off8[2]  = 8'(rand_bits(8));
        off11[0] = 11'h123;
        off11[1] = 11'h7F0;
        for (int k = 0; k < 3; k++)
        begin
                cond = 4'(rand_bits(4) % 14);   // 1110 and 1111 are not B<cond>
                run_thumb({4'b1101, cond, off8[k]},
                          branch_word(cond, 1'b0, {{16{off8[k][7]}}, off8[k]}), "B<cond>");
        end
        for (int k = 0; k < 2; k++)
                run_thumb({5'b11100, off11[k]},
                          branch_word(`COND_AL, 1'b0, {{13{off11[k][10]}}, off11[k]}), "B");
        imm8 = 8'(rand_bits(8));
        run_thumb({8'hDF, imm8}, {3'b000, `COND_AL, 4'b1111, 16'd0, imm8}, "SWI");
        rm = 4'(rand_bits(4));
        run_thumb({9'b010001110, rm, 3'b000}, {3'b000, `COND_AL, 24'h12_FFF1, rm}, "BX");
endtask

task automatic bl_pair();
        logic [10:0]    pre [2];
        logic [10:0]    suf [2];
        logic [21:0]    joined;
        pre[0] = 11'h002;
        suf[0] = 11'h345;
        pre[1] = 11'h7FF;               // Negative target
        suf[1] = 11'(rand_bits(11));
        for (int k = 0; k < 2; k++)
        begin
                issue_thumb({5'b11110, pre[k]}, 1'b1, 1'b1);
                check_out({3'b000, `COND_NV, 16'd0, 1'b0, pre[k]}, 1'b0, 1'b0, 1'b0,
                          "BL prefix");
                joined = {pre[k], suf[k]};
                issue_thumb({5'b11111, suf[k]}, 1'b1, 1'b1);
                check_out(branch_word(`COND_AL, 1'b1, {{2{joined[21]}}, joined} - 24'd1),
                          1'b0, 1'b0, 1'b0, "BL suffix");
        end
endtask

task automatic undefined_encodings();
        halfword_t hw [5];
        hw[0] = 16'h6808;               // LDR immediate
        hw[1] = 16'hB500;               // PUSH {LR}
        hw[2] = 16'hBE00;               // BKPT
        hw[3] = 16'hE800;               // BLX suffix
        hw[4] = 16'h4780;               // BLX Rm, high op 11
        for (int k = 0; k < 5; k++)
        begin
                issue_thumb(hw[k], 1'b0, 1'b0);
                assert (und && out_valid)
                else
                begin
                        $display("error: time %0t halfword %h not flagged undefined",
                                 $time, hw[k]);
                        abort_run();
                end
        end
endtask

//////////////////////////////////////////////////
// Main sequence
//////////////////////////////////////////////////

initial
begin
        lfsr              = 16'd11197;
        rst_n             = 1'b0;
        instruction       = '0;
        instruction_valid = 1'b0;
        cpsr_t            = 1'b0;
        irq               = 1'b1;       // High so reset must hold outputs low
        fiq               = 1'b1;
        last_latency      = 0;
        reset_and_latency();
        arm_pass_through();
        data_processing();
        control_flow();
        bl_pair();
        undefined_encodings();
        $display("RESULT: PASS");
        $finish;
end

endmodule

/* thumb_decoder.f */
+incdir+.
thumb_pkg.sv
thumb_class_decode.sv
thumb_dp_expand.sv
thumb_branch_expand.sv
thumb_decoder.sv
thumb_decoder_assertions.sv
tb_thumb_decoder.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_thumb_decoder
RTL_TOP   ?= thumb_decoder
FILELIST  ?= thumb_decoder.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
